// ==== sim/lcdPanelGolden.hex ====
// First data line: the 11 init command bytes in send order.
// Then 32 lines of 32 frame bytes each, buffer address order (page major).
AF 40 A6 A0 C8 A4 A2 2F 24 81 24
00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D 1E 1F
20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D 2E 2F 30 31 32 33 34 35 36 37 38 39 3A 3B 3C 3D 3E 3F
40 41 42 43 44 45 46 47 48 49 4A 4B 4C 4D 4E 4F 50 51 52 53 54 55 56 57 58 59 5A 5B 5C 5D 5E 5F
60 61 62 63 64 65 66 67 68 69 6A 6B 6C 6D 6E 6F 70 71 72 73 74 75 76 77 78 79 7A 7B 7C 7D 7E 7F
80 81 82 83 84 85 86 87 88 89 8A 8B 8C 8D 8E 8F 90 91 92 93 94 95 96 97 98 99 9A 9B 9C 9D 9E 9F
A0 A1 A2 A3 A4 A5 A6 A7 A8 A9 AA AB AC AD AE AF B0 B1 B2 B3 B4 B5 B6 B7 B8 B9 BA BB BC BD BE BF
C0 C1 C2 C3 C4 C5 C6 C7 C8 C9 CA CB CC CD CE CF D0 D1 D2 D3 D4 D5 D6 D7 D8 D9 DA DB DC DD DE DF
E0 E1 E2 E3 E4 E5 E6 E7 E8 E9 EA EB EC ED EE EF F0 F1 F2 F3 F4 F5 F6 F7 F8 F9 FA FB FC FD FE FF
55 54 57 56 51 50 53 52 5D 5C 5F 5E 59 58 5B 5A 45 44 47 46 41 40 43 42 4D 4C 4F 4E 49 48 4B 4A
75 74 77 76 71 70 73 72 7D 7C 7F 7E 79 78 7B 7A 65 64 67 66 61 60 63 62 6D 6C 6F 6E 69 68 6B 6A
15 14 17 16 11 10 13 12 1D 1C 1F 1E 19 18 1B 1A 05 04 07 06 01 00 03 02 0D 0C 0F 0E 09 08 0B 0A
35 34 37 36 31 30 33 32 3D 3C 3F 3E 39 38 3B 3A 25 24 27 26 21 20 23 22 2D 2C 2F 2E 29 28 2B 2A
D5 D4 D7 D6 D1 D0 D3 D2 DD DC DF DE D9 D8 DB DA C5 C4 C7 C6 C1 C0 C3 C2 CD CC CF CE C9 C8 CB CA
F5 F4 F7 F6 F1 F0 F3 F2 FD FC FF FE F9 F8 FB FA E5 E4 E7 E6 E1 E0 E3 E2 ED EC EF EE E9 E8 EB EA
95 94 97 96 91 90 93 92 9D 9C 9F 9E 99 98 9B 9A 85 84 87 86 81 80 83 82 8D 8C 8F 8E 89 88 8B 8A
B5 B4 B7 B6 B1 B0 B3 B2 BD BC BF BE B9 B8 BB BA A5 A4 A7 A6 A1 A0 A3 A2 AD AC AF AE A9 A8 AB AA
AA AB A8 A9 AE AF AC AD A2 A3 A0 A1 A6 A7 A4 A5 BA BB B8 B9 BE BF BC BD B2 B3 B0 B1 B6 B7 B4 B5
8A 8B 88 89 8E 8F 8C 8D 82 83 80 81 86 87 84 85 9A 9B 98 99 9E 9F 9C 9D 92 93 90 91 96 97 94 95
EA EB E8 E9 EE EF EC ED E2 E3 E0 E1 E6 E7 E4 E5 FA FB F8 F9 FE FF FC FD F2 F3 F0 F1 F6 F7 F4 F5
CA CB C8 C9 CE CF CC CD C2 C3 C0 C1 C6 C7 C4 C5 DA DB D8 D9 DE DF DC DD D2 D3 D0 D1 D6 D7 D4 D5
2A 2B 28 29 2E 2F 2C 2D 22 23 20 21 26 27 24 25 3A 3B 38 39 3E 3F 3C 3D 32 33 30 31 36 37 34 35
0A 0B 08 09 0E 0F 0C 0D 02 03 00 01 06 07 04 05 1A 1B 18 19 1E 1F 1C 1D 12 13 10 11 16 17 14 15
6A 6B 68 69 6E 6F 6C 6D 62 63 60 61 66 67 64 65 7A 7B 78 79 7E 7F 7C 7D 72 73 70 71 76 77 74 75
4A 4B 48 49 4E 4F 4C 4D 42 43 40 41 46 47 44 45 5A 5B 58 59 5E 5F 5C 5D 52 53 50 51 56 57 54 55
FF FE FD FC FB FA F9 F8 F7 F6 F5 F4 F3 F2 F1 F0 EF EE ED EC EB EA E9 E8 E7 E6 E5 E4 E3 E2 E1 E0
DF DE DD DC DB DA D9 D8 D7 D6 D5 D4 D3 D2 D1 D0 CF CE CD CC CB CA C9 C8 C7 C6 C5 C4 C3 C2 C1 C0
BF BE BD BC BB BA B9 B8 B7 B6 B5 B4 B3 B2 B1 B0 AF AE AD AC AB AA A9 A8 A7 A6 A5 A4 A3 A2 A1 A0
9F 9E 9D 9C 9B 9A 99 98 97 96 95 94 93 92 91 90 8F 8E 8D 8C 8B 8A 89 88 87 86 85 84 83 82 81 80
7F 7E 7D 7C 7B 7A 79 78 77 76 75 74 73 72 71 70 6F 6E 6D 6C 6B 6A 69 68 67 66 65 64 63 62 61 60
5F 5E 5D 5C 5B 5A 59 58 57 56 55 54 53 52 51 50 4F 4E 4D 4C 4B 4A 49 48 47 46 45 44 43 42 41 40
3F 3E 3D 3C 3B 3A 39 38 37 36 35 34 33 32 31 30 2F 2E 2D 2C 2B 2A 29 28 27 26 25 24 23 22 21 20
1F 1E 1D 1C 1B 1A 19 18 17 16 15 14 13 12 11 10 0F 0E 0D 0C 0B 0A 09 08 07 06 05 04 03 02 01 00

// ==== lcdPanel.f ====
rtl/lcdPkg.sv
rtl/frameBuffer.sv
rtl/spiWriter.sv
rtl/lcdControl.sv
rtl/lcdPanelTop.sv
sim/tbLcdPanel.sv

// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing --timescale 1ns/10ps
TOP      := tbLcdPanel
FILELIST := lcdPanel.f
OBJDIR   := obj_dir

SOURCES  := $(shell cat $(FILELIST))
SIMBIN   := $(OBJDIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test: $(SIMBIN)
	./$(SIMBIN)

$(SIMBIN): $(FILELIST) $(SOURCES)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== sim/tbLcdPanel.sv ====
`timescale 1ns/10ps

module tbLcdPanel import lcdPkg::*; ();

	localparam int BytesPerLine = 32;
	localparam int DataLines = BufferDepth / BytesPerLine;
	localparam int ByteBudget = 2 * SpiHalfPeriod * ByteWidth + 16; // Clocks per serial byte, with slack.
	localparam int DrawBytes = PageCount * (3 + ColumnCount);
	localparam int InitLimit = InitCount * ByteBudget + 100;
	localparam int FrameLimit = int'(RefreshTicks) + DrawBytes * ByteBudget + 100;
	localparam int IdleCycles = 1000;

	logic CLK;
	logic RSTn;
	logic WrEn;
	logic [AddrWidth-1:0] WrAddr;
	logic [ByteWidth-1:0] WrData;
	logic LcdCsn;
	logic LcdA0;
	logic LcdSclk;
	logic LcdMosi;
	logic FrameDone;

	logic [ByteWidth-1:0] initGolden [0:InitCount-1];
	logic [ByteWidth-1:0] frameGolden [0:BufferDepth-1];
	logic [ByteWidth-1:0] tokenQ [$];
	logic [ByteWidth:0] capQ [$];      // A0 above the byte.
	int doneBytes [$];                 // Capture count at each FrameDone.
	int writeOrder [0:BufferDepth-1];

	logic [ByteWidth-1:0] shiftIn = '0;
	int bitsSeen = 0;

	lcdPanelTop dut (
		.CLK       (CLK),
		.RSTn      (RSTn),
		.WrEn      (WrEn),
		.WrAddr    (WrAddr),
		.WrData    (WrData),
		.LcdCsn    (LcdCsn),
		.LcdA0     (LcdA0),
		.LcdSclk   (LcdSclk),
		.LcdMosi   (LcdMosi),
		.FrameDone (FrameDone)
	);

	always #5 CLK = ~CLK;

	// Panel side receiver. MOSI only moves on falling SCLK.
	always @(posedge LcdSclk) begin
		if (!LcdCsn) begin
			shiftIn = {shiftIn[ByteWidth-2:0], LcdMosi};
			bitsSeen = bitsSeen + 1;
			if (bitsSeen == ByteWidth) begin
				capQ.push_back({LcdA0, shiftIn});
				bitsSeen = 0;
			end
		end
	end

	always @(posedge LcdCsn) begin
		if (bitsSeen != 0) begin
			abortRun($sformatf("chip select went high after %0d bits of a byte", bitsSeen));
		end
	end

	always @(negedge CLK) begin
		if (FrameDone) begin
			doneBytes.push_back(capQ.size());
		end
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			abortRun($sformatf("MISMATCH %s: actual 0x%0h, expected 0x%0h", name, actual, expected));
		end
	endtask

	task automatic checkCapture(input int idx, input logic a0, input logic [ByteWidth-1:0] expected,
			input string what);
		checkValue($sformatf("LcdA0 %s", what), 32'(capQ[idx][ByteWidth]), 32'(a0));
		checkValue($sformatf("LcdMosi %s", what), 32'(capQ[idx][ByteWidth-1:0]), 32'(expected));
	endtask

	function automatic logic isHexChar(input logic [7:0] ch);
		return (ch >= "0" && ch <= "9") || (ch >= "a" && ch <= "f") || (ch >= "A" && ch <= "F");
	endfunction

	function automatic logic [3:0] hexValue(input logic [7:0] ch);
		if (ch >= "a") begin
			return 4'(ch - "a" + 8'd10);
		end else if (ch >= "A") begin
			return 4'(ch - "A" + 8'd10);
		end
		return 4'(ch - "0");
	endfunction

	// Splits one text line into hex bytes.
	task automatic splitHex(input string text);
		int digits;
		logic [7:0] ch;
		logic [ByteWidth-1:0] value;
		tokenQ.delete();
		digits = 0;
		value = '0;
		for (int i = 0; i < text.len(); i++) begin
			ch = text.getc(i);
			if (ch == "/") begin
				break; // Comment to end of line.
			end
			if (isHexChar(ch)) begin
				value = {value[3:0], hexValue(ch)};
				digits = digits + 1;
			end else begin
				if (digits > 0) begin
					tokenQ.push_back(value);
				end
				digits = 0;
				value = '0;
			end
		end
		if (digits > 0) begin
			tokenQ.push_back(value);
		end
	endtask

	task automatic loadGolden();
		int fd;
		int dataLine;
		string text;
		fd = $fopen("sim/lcdPanelGolden.hex", "r");
		if (fd == 0) begin
			abortRun("could not open sim/lcdPanelGolden.hex");
		end
		dataLine = 0;
		while (!$feof(fd)) begin
			if ($fgets(text, fd) == 0) begin
				break;
			end
			splitHex(text);
			if (tokenQ.size() == 0) begin
				continue;
			end
			if (dataLine == 0) begin
				if (tokenQ.size() != InitCount) begin
					abortRun("golden init line has the wrong number of bytes");
				end
				for (int i = 0; i < InitCount; i++) begin
					initGolden[i] = tokenQ[i];
				end
			end else begin
				if (dataLine > DataLines || tokenQ.size() != BytesPerLine) begin
					abortRun($sformatf("golden frame line %0d is malformed", dataLine));
				end
				for (int i = 0; i < BytesPerLine; i++) begin
					frameGolden[(dataLine - 1) * BytesPerLine + i] = tokenQ[i];
				end
			end
			dataLine = dataLine + 1;
		end
		$fclose(fd);
		if (dataLine != DataLines + 1) begin
			abortRun("golden file does not hold a full frame");
		end
	endtask

	// Random permutation of buffer addresses.
	task automatic shuffleWrites();
		int j;
		int held;
		for (int i = 0; i < BufferDepth; i++) begin
			writeOrder[i] = i;
		end
		for (int i = BufferDepth - 1; i > 0; i--) begin
			j = int'($urandom_range(i, 0));
			held = writeOrder[i];
			writeOrder[i] = writeOrder[j];
			writeOrder[j] = held;
		end
	endtask

	task automatic writeFrame();
		for (int i = 0; i < BufferDepth; i++) begin
			@(negedge CLK);
			WrEn = 1'b1;
			WrAddr = AddrWidth'(writeOrder[i]);
			WrData = frameGolden[writeOrder[i]];
		end
		@(negedge CLK);
		WrEn = 1'b0;
	endtask

	task automatic waitFrameDone(input int count, input int limit, input string what);
		int cycles;
		cycles = 0;
		while (doneBytes.size() < count) begin
			if (cycles >= limit) begin
				abortRun($sformatf("timed out after %0d cycles waiting for %s", limit, what));
			end
			@(posedge CLK);
			cycles = cycles + 1;
		end
	endtask

	initial begin
		int idx;
		CLK = 1'b0;
		RSTn = 1'b0;
		WrEn = 1'b0;
		WrAddr = '0;
		WrData = '0;
		void'($urandom(80305));
		loadGolden();
		shuffleWrites();

		for (int i = 0; i < 8; i++) begin
			@(negedge CLK);
			checkValue("LcdCsn in reset", 32'(LcdCsn), 32'd1);
			checkValue("LcdSclk in reset", 32'(LcdSclk), 32'd0);
		end
		RSTn = 1'b1;
		@(negedge CLK);
		checkValue("LcdCsn after reset", 32'(LcdCsn), 32'd1);
		checkValue("LcdSclk after reset", 32'(LcdSclk), 32'd0);

		// Buffer is full long before the first refresh.
		writeFrame();

		waitFrameDone(1, InitLimit, "the end of the init sequence");
		checkValue("bytes at init FrameDone", doneBytes[0], InitCount);
		for (int i = 0; i < InitCount; i++) begin
			checkCapture(i, 1'b0, initGolden[i], $sformatf("init byte %0d", i));
		end

		waitFrameDone(2, FrameLimit, "the end of the first draw frame");
		checkValue("bytes at frame FrameDone", doneBytes[1], InitCount + DrawBytes);
		idx = InitCount;
		for (int p = 0; p < PageCount; p++) begin
			checkCapture(idx, 1'b0, PageCmdBase + ByteWidth'(p), $sformatf("page %0d command", p));
			checkCapture(idx + 1, 1'b0, ColumnHighCmd, $sformatf("page %0d column high", p));
			checkCapture(idx + 2, 1'b0, ColumnLowCmd, $sformatf("page %0d column low", p));
			idx = idx + 3;
			for (int c = 0; c < ColumnCount; c++) begin
				checkCapture(idx, 1'b1, frameGolden[p * ColumnCount + c],
					$sformatf("page %0d column %0d", p, c));
				idx = idx + 1;
			end
		end

		// Bus stays quiet until the next refresh.
		for (int i = 0; i < IdleCycles; i++) begin
			@(negedge CLK);
			checkValue("LcdCsn after frame", 32'(LcdCsn), 32'd1);
		end
		checkValue("captured byte count", capQ.size(), InitCount + DrawBytes);
		checkValue("FrameDone pulse count", doneBytes.size(), 2);

		$display("sim passed");
		$finish;
	end

endmodule

// ==== rtl/lcdPanelTop.sv ====
`timescale 1ns/10ps

module lcdPanelTop import lcdPkg::*; (
	input  logic                 CLK,
	input  logic                 RSTn,

	input  logic                 WrEn,
	input  logic [AddrWidth-1:0] WrAddr,
	input  logic [ByteWidth-1:0] WrData,

	output logic                 LcdCsn,
	output logic                 LcdA0,
	output logic                 LcdSclk,
	output logic                 LcdMosi,

	output logic                 FrameDone
);

	logic [AddrWidth-1:0] readAddr;
	logic [ByteWidth-1:0] readData;

	logic spiStart;
	logic [WordWidth-1:0] spiWord;
	logic spiDone;

	frameBuffer uFrameBuffer (
		.CLK      (CLK),
		.WrEn     (WrEn),
		.WrAddr   (WrAddr),
		.WrData   (WrData),
		.ReadAddr (readAddr),
		.ReadData (readData)
	);

	// Init and refresh sequencing.
	lcdControl uControl (
		.CLK       (CLK),
		.RSTn      (RSTn),
		.ReadData  (readData),
		.ReadAddr  (readAddr),
		.SpiDone   (spiDone),
		.SpiStart  (spiStart),
		.SpiWord   (spiWord),
		.FrameDone (FrameDone)
	);

	spiWriter uWriter (
		.CLK      (CLK),
		.RSTn     (RSTn),
		.SpiStart (spiStart),
		.SpiWord  (spiWord),
		.SpiDone  (spiDone),
		.LcdCsn   (LcdCsn),
		.LcdA0    (LcdA0),
		.LcdSclk  (LcdSclk),
		.LcdMosi  (LcdMosi)
	);

endmodule

// ==== rtl/lcdControl.sv ====
`timescale 1ns/10ps

module lcdControl import lcdPkg::*; (
	input  logic                 CLK,
	input  logic                 RSTn,

	input  logic [ByteWidth-1:0] ReadData,
	output logic [AddrWidth-1:0] ReadAddr,

	input  logic                 SpiDone,
	output logic                 SpiStart,
	output logic [WordWidth-1:0] SpiWord,

	output logic                 FrameDone
);

	logic [RefreshBits-1:0] refreshCnt;
	logic refreshWrap;

	ctrlModeE mode;

	logic [InitBits-1:0] initIndex;
	logic [1:0] drawStep;   // Page cmd, column high, column low, data.
	logic [PageBits-1:0] page;
	logic [ColumnBits-1:0] column;

	lcdTagE drawTag;
	logic [ByteWidth-1:0] drawByte;

	logic lastInit;
	logic lastColumn;
	logic lastPage;

	// Free running refresh timer.
	assign refreshWrap = (refreshCnt == RefreshTicks);

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			refreshCnt <= '0;
		end else if (refreshWrap) begin
			refreshCnt <= '0;
		end else begin
			refreshCnt <= refreshCnt + 1'b1;
		end
	end

	assign lastInit = (initIndex == InitBits'(InitCount - 1));
	assign lastColumn = (column == ColumnBits'(ColumnCount - 1));
	assign lastPage = (page == PageBits'(PageCount - 1));

	// Buffer address follows the counters directly.
	assign ReadAddr = AddrWidth'(page * ColumnCount + column);

	// Word for the current draw step.
	always_comb begin
		drawTag = TagCommand;
		case (drawStep)
			2'd0: drawByte = PageCmdBase | ByteWidth'(page);
			2'd1: drawByte = ColumnHighCmd;
			2'd2: drawByte = ColumnLowCmd;
			default: begin
				drawTag = TagData;
				drawByte = ReadData;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			mode <= ModeInit;
			initIndex <= '0;
			drawStep <= '0;
			page <= '0;
			column <= '0;
			SpiStart <= 1'b0;
			SpiWord <= {TagIdle, ByteWidth'(0)};
			FrameDone <= 1'b0;
		end else begin
			FrameDone <= 1'b0;

			case (mode)
				ModeInit: begin
					if (SpiDone) begin
						SpiStart <= 1'b0;
						if (lastInit) begin
							initIndex <= '0;
							FrameDone <= 1'b1;
							mode <= ModeWait;
						end else begin
							initIndex <= initIndex + 1'b1;
						end
					end else begin
						// Held until the writer reports done.
						SpiWord <= {TagCommand, InitCommands[initIndex]};
						SpiStart <= 1'b1;
					end
				end

				ModeDraw: begin
					if (SpiDone) begin
						SpiStart <= 1'b0;
						if (drawStep != 2'd3) begin
							drawStep <= drawStep + 1'b1;
						end else if (!lastColumn) begin
							column <= column + 1'b1;
						end else begin
							// Page complete.
							column <= '0;
							drawStep <= '0;
							page <= page + 1'b1; // Wraps to zero after the last page.
							if (lastPage) begin
								FrameDone <= 1'b1;
								mode <= ModeWait;
							end
						end
					end else begin
						SpiWord <= {drawTag, drawByte};
						SpiStart <= 1'b1;
					end
				end

				default: begin
					// Only an idle controller takes a refresh tick.
					if (refreshWrap) begin
						mode <= ModeDraw;
					end
				end
			endcase
		end
	end

endmodule

// ==== rtl/spiWriter.sv ====
`timescale 1ns/10ps

module spiWriter import lcdPkg::*; (
	input  logic                 CLK,
	input  logic                 RSTn,

	input  logic                 SpiStart,
	input  logic [WordWidth-1:0] SpiWord,
	output logic                 SpiDone,

	output logic                 LcdCsn,
	output logic                 LcdA0,
	output logic                 LcdSclk,
	output logic                 LcdMosi
);

	spiStateE state;

	logic [DivBits-1:0] divCnt;   // Clocks within one SCLK half.
	logic [2:0] bitCnt;           // Bits already sent.
	logic [ByteWidth-1:0] shiftReg;
	logic a0Reg;
	logic sclkReg;

	lcdTagE startTag;
	logic halfDone;

	assign startTag = lcdTagE'(SpiWord[WordWidth-1:ByteWidth]);
	assign halfDone = (divCnt == DivBits'(SpiHalfPeriod - 1));

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			state <= SpiIdle;
			divCnt <= '0;
			bitCnt <= '0;
			shiftReg <= '0;
			a0Reg <= 1'b0;
			sclkReg <= 1'b0;
		end else begin
			case (state)
				SpiIdle: begin
					if (SpiStart) begin
						a0Reg <= SpiWord[ByteWidth];
						divCnt <= '0;
						bitCnt <= '0;
						if (startTag == TagIdle) begin
							// Nothing goes on the wire.
							shiftReg <= '0;
							state <= SpiFinish;
						end else begin
							shiftReg <= SpiWord[ByteWidth-1:0];
							state <= SpiShift;
						end
					end
				end

				SpiShift: begin
					if (halfDone) begin
						divCnt <= '0;
						sclkReg <= !sclkReg;
						// Falling SCLK moves on to the next bit.
						if (sclkReg) begin
							shiftReg <= {shiftReg[ByteWidth-2:0], 1'b0};
							bitCnt <= bitCnt + 1'b1;
							if (bitCnt == 3'd7) begin
								state <= SpiFinish; // Eighth period complete.
							end
						end
					end else begin
						divCnt <= divCnt + 1'b1;
					end
				end

				SpiFinish: begin
					state <= SpiIdle; // SpiStart is ignored here.
				end

				default: begin
					state <= SpiIdle;
				end
			endcase
		end
	end

	assign SpiDone = (state == SpiFinish);

	// Chip select frames the shift phase only.
	assign LcdCsn = (state != SpiShift);
	assign LcdA0 = a0Reg;
	assign LcdSclk = sclkReg;
	assign LcdMosi = shiftReg[ByteWidth-1]; // MSB first.

endmodule

// ==== rtl/frameBuffer.sv ====
`timescale 1ns/10ps

// One byte per column per page, page major.
module frameBuffer import lcdPkg::*; (
	input  logic                 CLK,

	input  logic                 WrEn,
	input  logic [AddrWidth-1:0] WrAddr,
	input  logic [ByteWidth-1:0] WrData,

	input  logic [AddrWidth-1:0] ReadAddr,
	output logic [ByteWidth-1:0] ReadData
);

	logic [ByteWidth-1:0] mem [0:BufferDepth-1];

	// Host side.
	always_ff @(posedge CLK) begin
		if (WrEn) begin
			mem[WrAddr] <= WrData;
		end
	end

	// Controller side sees the byte in the same cycle.
	assign ReadData = mem[ReadAddr];

endmodule

// ==== rtl/lcdPkg.sv ====
package lcdPkg;

	// Refresh period minus one.
	localparam int RefreshBits = 21;
	localparam logic [RefreshBits-1:0] RefreshTicks = 21'd1_249_999; // 25 ms at 50 MHz.

	// Serial clock runs at CLK/8.
	localparam int SpiHalfPeriod = 4;
	localparam int DivBits = $clog2(SpiHalfPeriod);

	// Frame buffer geometry.
	localparam int PageCount = 8;
	localparam int ColumnCount = 128;
	localparam int BufferDepth = PageCount * ColumnCount;
	localparam int AddrWidth = $clog2(BufferDepth);
	localparam int PageBits = $clog2(PageCount);
	localparam int ColumnBits = $clog2(ColumnCount);

	localparam int ByteWidth = 8;
	localparam int WordWidth = ByteWidth + 2; // Tag on top of the byte.

	// Bit 0 of the tag lands on A0.
	typedef enum logic [1:0] {
		TagCommand = 2'b00,
		TagData    = 2'b01,
		TagIdle    = 2'b11
	} lcdTagE;

	localparam int InitCount = 11;
	localparam int InitBits = $clog2(InitCount);

	localparam logic [ByteWidth-1:0] InitCommands [0:InitCount-1] = '{
		8'hAF, // Display on.
		8'h40, // Start line zero.
		8'hA6, // Normal, not inverted.
		8'hA0, // ADC normal.
		8'hC8, // COM scan reversed.
		8'hA4, // All points normal.
		8'hA2, // Bias 1/9.
		8'h2F, // Booster, regulator and follower on.
		8'h24, // Regulator resistor ratio.
		8'h81, // Electronic volume mode.
		8'h24  // Volume value.
	};

	// Draw commands.
	localparam logic [ByteWidth-1:0] PageCmdBase = 8'hB0;
	localparam logic [ByteWidth-1:0] ColumnHighCmd = 8'h10;
	localparam logic [ByteWidth-1:0] ColumnLowCmd = 8'h00;

	typedef enum logic [1:0] {ModeInit, ModeDraw, ModeWait} ctrlModeE;

	typedef enum logic [1:0] {SpiIdle, SpiShift, SpiFinish} spiStateE;

endpackage
